// ==== common/fm_defs.svh ====
`ifndef FM_DEFS_SVH
`define FM_DEFS_SVH

// lane count, 2 and 8 also build
`define FM_LANES 4
`define FM_SEL_W ($clog2(`FM_LANES)) // lane select width

`define FM_PHASE_W 10 // [9] half sign, [8] quarter mirror, [7:0] index
`define FM_IDX_W 8 // table address width
`define FM_ATT_W 10 // envelope attenuation, 1 unit = 4 log steps

`define FM_SIN_W 12 // log-sine table word
`define FM_MANT_W 10 // exponent table word, implicit leading 1 on top
`define FM_LOG_W 13 // log domain sum, saturates at all ones

`define FM_LANE_W 13 // signed lane sample
`define FM_OUT_W 14 // signed mixer output

`endif

// ==== common/fm_ctrl_pkg.sv ====
package fm_ctrl_pkg;

	localparam int unsigned FM_OP_W = 2; // opcode field width

	typedef enum logic [FM_OP_W-1:0]
	{
		op_off = 2'd0, // lane silent
		op_sine = 2'd1, // full signed sine
		op_abs_sine = 2'd2 // negative half folded up
	} fm_op_e;

	// true when the lane output is forced to zero
	function automatic logic fm_op_mutes(fm_op_e op);
		return op == op_off;
	endfunction

	// only the plain sine keeps the lower half negative
	function automatic logic fm_op_negates(fm_op_e op, logic half);
		return (op == op_sine) && half;
	endfunction

endpackage

// ==== common/fm_data_pkg.sv ====
`include "fm_defs.svh"

package fm_data_pkg;

	// one request toward a lane, 22 bits
	typedef struct packed
	{
		logic [`FM_PHASE_W-1:0] phase; // sign, mirror, index
		logic [`FM_ATT_W-1:0] att; // envelope attenuation
		fm_ctrl_pkg::fm_op_e op; // waveform select
	} fm_req_t;

	// one lane result, 13 bits
	typedef struct packed
	{
		logic signed [`FM_LANE_W-1:0] sample; // two's complement
	} fm_lane_out_t;

endpackage

// ==== verilog/fm_slot_dispatch.sv ====
`timescale 1ns/1ps
`include "fm_defs.svh"

module fm_slot_dispatch
(
	input logic clk,
	input logic arst_n,
	input logic in_valid, // one-cycle request strobe
	input logic [`FM_SEL_W-1:0] in_lane, // target lane
	input fm_data_pkg::fm_req_t in_req,
	output logic [`FM_LANES-1:0] lane_valid, // one strobe per lane
	output fm_data_pkg::fm_req_t lane_req [`FM_LANES]
);

	logic [`FM_LANES-1:0] hit; // decoded lane select, gated by in_valid

	always_comb
	begin
		for (int i = 0; i < `FM_LANES; i++)
		begin
			hit[i] = in_valid && (in_lane == `FM_SEL_W'(i));
		end
	end

	// strobes, one cycle after the request
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			lane_valid <= '0;
		end
		else
		begin
			lane_valid <= hit; // pulses only the addressed lane
		end
	end

	// slot contents, the untouched lanes keep their last request
	always_ff @(posedge clk)
	begin
		for (int i = 0; i < `FM_LANES; i++)
		begin
			if (hit[i])
			begin
				lane_req[i] <= in_req;
			end
		end
	end

endmodule

// ==== fm_lane/fm_logsin_rom.sv ====
`timescale 1ns/1ps
`include "fm_defs.svh"

module fm_logsin_rom
(
	input logic clk,
	input logic [`FM_IDX_W-1:0] addr, // folded quarter-wave index
	output logic [`FM_SIN_W-1:0] logsin // -log2(sin) in 1/256 steps
);

	localparam int DEPTH = 1 << `FM_IDX_W;
	localparam real HALF_PI = 1.5707963267948966;

	logic [`FM_SIN_W-1:0] lut [DEPTH];

	// quarter wave sampled at bin centres, so no entry hits sin(0)
	initial
	begin : fill
		real ang;
		real lg;
		for (int k = 0; k < DEPTH; k++)
		begin
			ang = (real'(k) + 0.5) / real'(DEPTH) * HALF_PI;
			lg = -$ln($sin(ang)) / $ln(2.0) * 256.0; // attenuation in log steps
			lut[k] = `FM_SIN_W'($rtoi(lg + 0.5)); // round to nearest, always >= 0
		end
	end

	// registered read, one cycle latency
	always_ff @(posedge clk)
	begin
		logsin <= lut[addr];
	end

endmodule

// ==== fm_lane/fm_exp_rom.sv ====
`timescale 1ns/1ps
`include "fm_defs.svh"

module fm_exp_rom
(
	input logic clk,
	input logic [`FM_IDX_W-1:0] addr, // fractional part of the log value
	output logic [`FM_MANT_W-1:0] mant // linear mantissa minus the hidden 1
);

	localparam int DEPTH = 1 << `FM_IDX_W;

	logic [`FM_MANT_W-1:0] lut [DEPTH];

	// 2^(k/256) scaled to 1024, leading one dropped
	initial
	begin : fill
		real lin;
		for (int k = 0; k < DEPTH; k++)
		begin
			lin = $pow(2.0, real'(k) / real'(DEPTH)) * 1024.0;
			lut[k] = `FM_MANT_W'($rtoi(lin + 0.5) - 1024); // top entry is 1018
		end
	end

	always_ff @(posedge clk)
	begin
		mant <= lut[addr]; // registered like the log-sine table
	end

endmodule

// ==== fm_lane/fm_operator_lane.sv ====
`timescale 1ns/1ps
`include "fm_defs.svh"

module fm_operator_lane
(
	input logic clk,
	input logic arst_n,
	input logic req_valid, // one-cycle strobe from the dispatcher
	input fm_data_pkg::fm_req_t req,
	output logic res_valid, // five cycles after req_valid
	output fm_data_pkg::fm_lane_out_t res
);

	import fm_ctrl_pkg::*;

	localparam int SHIFT_W = `FM_LOG_W - `FM_IDX_W; // integer part of the log sum

	// what rides alongside the data through stages 1 to 4
	typedef struct packed
	{
		logic vld; // stage holds a live request
		logic half; // phase sign bit
		fm_op_e op; // waveform select
	} tag_t;

	tag_t tag_q [1:4];

	logic [`FM_IDX_W-1:0] s1_idx; // stage 1, folded index
	logic [`FM_ATT_W-1:0] s1_att;
	logic [`FM_SIN_W-1:0] s2_logsin; // stage 2, rom output
	logic [`FM_ATT_W-1:0] s2_att;
	logic [`FM_LOG_W:0] sum_w; // one spare bit to catch overflow
	logic [`FM_LOG_W-1:0] s3_log; // stage 3, saturated log sum
	logic [`FM_IDX_W-1:0] exp_addr;
	logic [`FM_MANT_W-1:0] s4_mant; // stage 4, rom output
	logic [SHIFT_W-1:0] s4_shift;
	logic [`FM_LANE_W-1:0] mag; // linear magnitude before sign
	logic signed [`FM_LANE_W-1:0] sample_d;

	fm_logsin_rom u_logsin
	(
		.clk (clk),
		.addr (s1_idx),
		.logsin (s2_logsin)
	);

	// attenuation weighs 4 log steps per unit
	assign sum_w = (`FM_LOG_W+1)'(s2_logsin) + (`FM_LOG_W+1)'({s2_att, 2'b00});

	// larger fraction means less attenuation, so read the table backwards
	assign exp_addr = ~s3_log[`FM_IDX_W-1:0];

	fm_exp_rom u_exp
	(
		.clk (clk),
		.addr (exp_addr),
		.mant (s4_mant)
	);

	// 2 * (1024 + entry), then one octave down per integer step
	assign mag = `FM_LANE_W'({1'b1, s4_mant, 1'b0} >> s4_shift);

	always_comb
	begin
		if (fm_op_mutes(tag_q[4].op))
			sample_d = '0;
		else if (fm_op_negates(tag_q[4].op, tag_q[4].half))
			sample_d = -$signed(mag); // lower half-wave of a plain sine
		else
			sample_d = $signed(mag); // upper half, or abs sine folded up
	end

	// data path through the five stages
	always_ff @(posedge clk)
	begin
		s1_idx <= req.phase[`FM_PHASE_W-2] ? ~req.phase[`FM_IDX_W-1:0]
			: req.phase[`FM_IDX_W-1:0]; // mirror the second quarter
		s1_att <= req.att;
		s2_att <= s1_att; // waits for the log-sine read
		s3_log <= sum_w[`FM_LOG_W] ? '1 : sum_w[`FM_LOG_W-1:0]; // clamp at 8191
		s4_shift <= s3_log[`FM_LOG_W-1:`FM_IDX_W];
		res.sample <= sample_d;
	end

	// valid-tagged delay line and result strobe
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			for (int i = 1; i <= 4; i++)
			begin
				tag_q[i] <= '0;
			end
			res_valid <= 1'b0;
		end
		else
		begin
			tag_q[1] <= '{vld: req_valid, half: req.phase[`FM_PHASE_W-1], op: req.op};
			for (int i = 2; i <= 4; i++)
			begin
				tag_q[i] <= tag_q[i-1];
			end
			res_valid <= tag_q[4].vld; // stage 5
		end
	end

endmodule

// ==== verilog/fm_mixer.sv ====
`timescale 1ns/1ps
`include "fm_defs.svh"

module fm_mixer
(
	input logic clk,
	input logic arst_n,
	input logic [`FM_LANES-1:0] res_valid, // per-lane result strobes
	input fm_data_pkg::fm_lane_out_t res [`FM_LANES],
	output logic out_valid,
	output logic signed [`FM_OUT_W-1:0] out_sample // saturated sum
);

	localparam int SUM_W = `FM_LANE_W + $clog2(`FM_LANES); // no overflow inside
	localparam logic signed [SUM_W-1:0] OUT_MAX = SUM_W'(2 ** (`FM_OUT_W - 1) - 1);
	localparam logic signed [SUM_W-1:0] OUT_MIN = SUM_W'(-(2 ** (`FM_OUT_W - 1)));

	logic signed [`FM_LANE_W-1:0] held [`FM_LANES]; // latest sample per lane
	logic signed [`FM_LANE_W-1:0] held_nx [`FM_LANES];
	logic signed [SUM_W-1:0] sum;
	logic signed [`FM_OUT_W-1:0] clamped;

	// sum uses the values as they stand after this cycle's update
	always_comb
	begin
		sum = '0;
		for (int i = 0; i < `FM_LANES; i++)
		begin
			held_nx[i] = res_valid[i] ? res[i].sample : held[i];
			sum = sum + SUM_W'(held_nx[i]); // sign extended
		end
		if (sum > OUT_MAX)
			clamped = `FM_OUT_W'(OUT_MAX);
		else if (sum < OUT_MIN)
			clamped = `FM_OUT_W'(OUT_MIN);
		else
			clamped = `FM_OUT_W'(sum);
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			for (int i = 0; i < `FM_LANES; i++)
			begin
				held[i] <= '0;
			end
			out_valid <= 1'b0;
			out_sample <= '0;
		end
		else
		begin
			held <= held_nx;
			out_valid <= |res_valid; // one output per strobing cycle
			if (|res_valid)
				out_sample <= clamped;
		end
	end

endmodule

// ==== verilog/fm_op_array.sv ====
`timescale 1ns/1ps
`include "fm_defs.svh"

module fm_op_array
(
	input logic clk,
	input logic arst_n,
	input logic in_valid, // request strobe
	input logic [`FM_SEL_W-1:0] in_lane,
	input fm_data_pkg::fm_req_t in_req,
	output logic out_valid, // 7 cycles after in_valid
	output logic signed [`FM_OUT_W-1:0] out_sample
);

	import fm_data_pkg::*;

	logic [`FM_LANES-1:0] lane_valid; // dispatcher to lanes
	fm_req_t lane_req [`FM_LANES];
	logic [`FM_LANES-1:0] res_valid; // lanes to mixer
	fm_lane_out_t lane_res [`FM_LANES];

	fm_slot_dispatch u_dispatch
	(
		.clk (clk),
		.arst_n (arst_n),
		.in_valid (in_valid),
		.in_lane (in_lane),
		.in_req (in_req),
		.lane_valid (lane_valid),
		.lane_req (lane_req)
	);

	// identical operator lanes
	for (genvar g = 0; g < `FM_LANES; g++)
	begin : g_lane
		fm_operator_lane u_lane
		(
			.clk (clk),
			.arst_n (arst_n),
			.req_valid (lane_valid[g]),
			.req (lane_req[g]),
			.res_valid (res_valid[g]),
			.res (lane_res[g])
		);
	end

	fm_mixer u_mixer
	(
		.clk (clk),
		.arst_n (arst_n),
		.res_valid (res_valid),
		.res (lane_res),
		.out_valid (out_valid),
		.out_sample (out_sample)
	);

endmodule

// ==== test/fm_op_array_assert.sv ====
`timescale 1ns/1ps
`include "fm_defs.svh"

module fm_op_array_assert
(
	input logic clk,
	input logic arst_n,
	input logic in_valid,
	input logic out_valid,
	input logic signed [`FM_OUT_W-1:0] out_sample
);

	int unsigned fail_count = 0; // read by the testbench at the end

	// every request comes out exactly 7 cycles later
	assert property (@(posedge clk) disable iff (!arst_n) in_valid |-> ##7 out_valid)
	else
	begin
		$error("out_valid missing 7 cycles after in_valid");
		fail_count++;
	end

	// and no output appears without a request 7 cycles earlier
	assert property (@(posedge clk) disable iff (!arst_n) out_valid |-> $past(in_valid, 7))
	else
	begin
		$error("out_valid without in_valid 7 cycles before");
		fail_count++;
	end

	assert property (@(posedge clk) disable iff (!arst_n) out_valid |-> !$isunknown(out_sample))
	else
	begin
		$error("out_sample has unknown bits while out_valid is high");
		fail_count++;
	end

	assert property (@(posedge clk) !arst_n |-> !out_valid) // quiet under reset
	else
	begin
		$error("out_valid high during reset");
		fail_count++;
	end

endmodule

bind fm_op_array fm_op_array_assert u_assert
(
	.clk (clk),
	.arst_n (arst_n),
	.in_valid (in_valid),
	.out_valid (out_valid),
	.out_sample (out_sample)
);

// ==== test/fm_op_array_tb.sv ====
`timescale 1ns/1ps
`include "fm_defs.svh"

module fm_op_array_tb;

	import fm_ctrl_pkg::*;
	import fm_data_pkg::*;

	localparam int CLK_NS = 20;
	localparam logic [31:0] SEED = 32'h34fbfccd;
	localparam int N_PHASE = 1 << `FM_PHASE_W; // full phase sweep
	localparam int N_ATT = 1 << `FM_ATT_W; // full attenuation sweep
	localparam int N_OFF = 32; // op_off requests in test 3
	localparam int N_RAND = 300;
	localparam int N_B2B = 256;
	localparam int N_REQ = N_PHASE + N_ATT + 1 + N_PHASE / 2 + N_OFF
		+ 2 * `FM_LANES + N_RAND + N_B2B;
	localparam longint WATCHDOG_NS = longint'(N_REQ * 7 + 200) * CLK_NS; // 7 cycles each
	localparam int OUT_MAX = (1 << (`FM_OUT_W - 1)) - 1;
	localparam int OUT_MIN = -(1 << (`FM_OUT_W - 1));

	logic clk;
	logic arst_n;
	logic in_valid;
	logic [`FM_SEL_W-1:0] in_lane;
	fm_req_t in_req;
	logic out_valid;
	logic signed [`FM_OUT_W-1:0] out_sample;

	logic signed [`FM_OUT_W-1:0] exp_q [$]; // expected mix in request order
	int unsigned cyc_q [$]; // cycle each request was driven
	int held_m [`FM_LANES]; // model of the mixer's held samples
	int unsigned cycle = 0;
	int unsigned checks = 0;
	int unsigned errors = 0;
	int unsigned clamps = 0; // model outputs that hit a rail
	int unsigned chk_mark = 0;
	int unsigned err_mark = 0;
	int unsigned test_num = 1;
	bit nonneg_chk = 1'b0; // test 3 wants no negative outputs

	fm_op_array uut
	(
		.clk (clk),
		.arst_n (arst_n),
		.in_valid (in_valid),
		.in_lane (in_lane),
		.in_req (in_req),
		.out_valid (out_valid),
		.out_sample (out_sample)
	);

	initial
	begin
		clk = 1'b0;
		forever #(CLK_NS / 2) clk = ~clk;
	end

	always @(posedge clk)
		cycle <= cycle + 1;

	// expected lane sample straight from the log-sine / exponent formulas
	function automatic int lane_sample(input logic [`FM_PHASE_W-1:0] phase,
		input logic [`FM_ATT_W-1:0] att, input fm_op_e op);
		int idx;
		int lg;
		int sum;
		int mant;
		int mag;
		real ang;
		if (op == op_off)
			return 0;
		idx = int'(phase[`FM_IDX_W-1:0]);
		if (phase[`FM_PHASE_W-2])
			idx = 255 - idx; // second quarter runs backwards
		ang = (real'(idx) + 0.5) / 256.0 * (3.141592653589793 / 2.0);
		lg = $rtoi(-$ln($sin(ang)) / $ln(2.0) * 256.0 + 0.5);
		sum = lg + 4 * int'(att);
		if (sum > 8191)
			sum = 8191;
		mant = 1024 + ($rtoi($pow(2.0, real'(255 - sum % 256) / 256.0) * 1024.0 + 0.5) - 1024);
		mag = (2 * mant) >> (sum / 256); // one octave per integer step
		if (op == op_sine && phase[`FM_PHASE_W-1])
			return -mag;
		return mag;
	endfunction

	// drive one request and queue the mixer result it should produce
	task automatic drive_req(input int lane, input logic [`FM_PHASE_W-1:0] phase,
		input logic [`FM_ATT_W-1:0] att, input fm_op_e op);
		int sum;
		@(posedge clk);
		#2;
		in_valid = 1'b1;
		in_lane = `FM_SEL_W'(lane);
		in_req.phase = phase;
		in_req.att = att;
		in_req.op = op;
		held_m[lane] = lane_sample(phase, att, op);
		sum = 0;
		for (int i = 0; i < `FM_LANES; i++)
			sum += held_m[i];
		if (sum > OUT_MAX || sum < OUT_MIN)
			clamps++;
		sum = (sum > OUT_MAX) ? OUT_MAX : ((sum < OUT_MIN) ? OUT_MIN : sum);
		exp_q.push_back(`FM_OUT_W'(sum));
		cyc_q.push_back(cycle);
	endtask

	task automatic idle_cycle();
		@(posedge clk);
		#2;
		in_valid = 1'b0;
	endtask

	// drain the pipe, then report this test
	task automatic finish_test(input string name);
		idle_cycle();
		while (exp_q.size() != 0)
			@(negedge clk);
		repeat (10) @(posedge clk); // room for a stray extra output
		$display("test %0d %s: %0d checks, %0d errors", test_num, name,
			checks - chk_mark, errors - err_mark);
		chk_mark = checks;
		err_mark = errors;
		test_num++;
	endtask

	// compare every output against the head of the queue
	always @(negedge clk)
	begin : compare
		logic signed [`FM_OUT_W-1:0] want;
		int unsigned at;
		if (arst_n && out_valid)
		begin
			assert (exp_q.size() != 0)
			else
			begin
				$display("Unexpected output at %0t ns with no request in flight", $time);
				errors++;
			end
			if (exp_q.size() != 0)
			begin
				want = exp_q.pop_front();
				at = cyc_q.pop_front();
				checks++;
				assert (out_sample === want)
				else
				begin
					$display("** Error %0t ns: out_sample %0d, expected %0d", $time, out_sample, want);
					errors++;
				end
				assert (cycle == at + 7)
				else
				begin
					$display("** Error %0t ns: latency %0d cycles, expected 7", $time, cycle - at);
					errors++;
				end
				if (nonneg_chk)
				begin
					assert (out_sample >= 0)
					else
					begin
						$display("** Error %0t ns: negative sample %0d", $time, out_sample);
						errors++;
					end
				end
			end
		end
	end

	initial
	begin : main
		int lane;
		int gap;
		logic [`FM_ATT_W-1:0] att;
		int unsigned total;
		void'($urandom(SEED));
		in_valid = 1'b0;
		in_lane = '0;
		in_req = '0;
		for (int i = 0; i < `FM_LANES; i++)
			held_m[i] = 0;
		arst_n = 1'b0;
		repeat (2) @(posedge clk);
		#2;
		arst_n = 1'b1;
		@(negedge clk);
		checks += 2;
		assert (out_valid === 1'b0)
		else
		begin
			$display("** Error %0t ns: out_valid %b after reset", $time, out_valid);
			errors++;
		end
		assert (out_sample === '0)
		else
		begin
			$display("** Error %0t ns: out_sample %0d after reset", $time, out_sample);
			errors++;
		end

		for (int p = 0; p < N_PHASE; p++)
			drive_req(0, `FM_PHASE_W'(p), '0, op_sine); // lanes 1 up stay at 0
		finish_test("sine phase sweep");

		for (int a = 0; a < N_ATT; a++)
			drive_req(0, '0, `FM_ATT_W'(a), op_sine); // index 0 gives the largest log sum
		finish_test("attenuation sweep");

		nonneg_chk = 1'b1;
		drive_req(0, '0, '0, op_off); // silences lane 0
		for (int p = N_PHASE / 2; p < N_PHASE; p++)
			drive_req(2 % `FM_LANES, `FM_PHASE_W'(p), '0, op_abs_sine);
		for (int i = 0; i < N_OFF; i++)
			drive_req(2 % `FM_LANES, `FM_PHASE_W'($urandom), '0, op_off);
		finish_test("abs sine and off");
		nonneg_chk = 1'b0;

		// peaks of one sign on every lane push the mix onto the rails
		for (int l = 0; l < `FM_LANES; l++)
			drive_req(l, `FM_PHASE_W'('h100), '0, op_sine);
		for (int l = 0; l < `FM_LANES; l++)
			drive_req(l, `FM_PHASE_W'('h300), '0, op_sine);
		for (int i = 0; i < N_RAND; i++)
		begin
			lane = $urandom % `FM_LANES;
			att = ($urandom % 4 == 0) ? `FM_ATT_W'($urandom) : `FM_ATT_W'($urandom % 32);
			drive_req(lane, `FM_PHASE_W'($urandom), att, fm_op_e'($urandom % 3));
			gap = $urandom % 3;
			repeat (gap) idle_cycle(); // mix of spaced and back-to-back strobes
		end
		finish_test($sformatf("random mix, %0d clamped", clamps));

		for (int i = 0; i < N_B2B; i++)
			drive_req(i % `FM_LANES, `FM_PHASE_W'($urandom), `FM_ATT_W'($urandom % 16), op_sine);
		finish_test("back-to-back strobes");

		total = errors + uut.u_assert.fail_count;
		$display("tests %0d, checks %0d, errors %0d, assertion failures %0d",
			test_num - 1, checks, errors, uut.u_assert.fail_count);
		if (total == 0)
		begin
			$display("Regression passed");
		end
		else
		begin
			$display("Regression failed");
		end
		$finish;
	end

	initial
	begin : watchdog
		#(WATCHDOG_NS);
		$display("Watchdog expired at %0t ns, the run did not finish", $time);
		$display("Regression failed");
		$finish;
	end

endmodule

// ==== list.f ====
+incdir+common
common/fm_ctrl_pkg.sv
common/fm_data_pkg.sv
verilog/fm_slot_dispatch.sv
fm_lane/fm_logsin_rom.sv
fm_lane/fm_exp_rom.sv
fm_lane/fm_operator_lane.sv
verilog/fm_mixer.sv
verilog/fm_op_array.sv
test/fm_op_array_assert.sv
test/fm_op_array_tb.sv

// ==== Bender.yml ====
package:
  name: fm_op_array

sources:
  - include_dirs:
      - common
    files:
      - common/fm_ctrl_pkg.sv
      - common/fm_data_pkg.sv
      - verilog/fm_slot_dispatch.sv
      - fm_lane/fm_logsin_rom.sv
      - fm_lane/fm_exp_rom.sv
      - fm_lane/fm_operator_lane.sv
      - verilog/fm_mixer.sv
      - verilog/fm_op_array.sv
  - target: test
    include_dirs:
      - common
    files:
      - test/fm_op_array_assert.sv
      - test/fm_op_array_tb.sv
